/* Bender.yml */
package:
  name: wiscCore

export_include_dirs:
  - logic

sources:
  - logic/wiscPkg.sv
  - logic/fetchUnit.sv
  - logic/fetchBuffer.sv
  - logic/control.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/executeUnit.sv
  - logic/wiscCore.sv
  - target: test
    files:
      - tb/wiscCoreTb.sv

/* logic/alu.sv */
// WISC ALU
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wiscPkg::aluOpE op,
    input  logic [15:0]    a,       // Rs
    input  logic [15:0]    b,       // Rt or immediate
    output logic [15:0]    result
);
    import wiscPkg::*;

    logic [3:0]  shAmt;
    logic [16:0] sum;
    logic [15:0] diff;
    logic [31:0] rolWide;
    logic [31:0] rorWide;
    logic [15:0] reversed;

    assign shAmt   = b[3:0];                    // Low 4 bits only
    assign sum     = {1'b0, a} + {1'b0, b};     // Bit 16 is carry out
    assign diff    = b - a;                     // WISC subtract order
    assign rolWide = {a, a} << shAmt;           // Upper half rotated left
    assign rorWide = {a, a} >> shAmt;           // Lower half rotated right

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            reversed[i] = a[15-i];
        end
    end

    always_comb begin
        case (op)
            ALU_ADD:   result = sum[15:0];
            ALU_SUB:   result = diff;
            ALU_XOR:   result = a ^ b;
            ALU_ANDN:  result = a & ~b;
            ALU_ROL:   result = rolWide[31:16];
            ALU_SLL:   result = a << shAmt;
            ALU_ROR:   result = rorWide[15:0];
            ALU_SRL:   result = a >> shAmt;
            ALU_SEQ:   result = {15'd0, a == b};
            ALU_SLT:   result = {15'd0, $signed(a) < $signed(b)};
            ALU_SLE:   result = {15'd0, $signed(a) <= $signed(b)};
            ALU_SCO:   result = {15'd0, sum[16]};
            ALU_BTR:   result = reversed;
            ALU_PASSB: result = b;                      // LBI
            ALU_SLBI:  result = {a[7:0], 8'h00} | b;    // Shift in low byte
            default:   result = 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

/* logic/control.sv */
// WISC instruction decoder
`timescale 1ns/10ps
`default_nettype none

module control (
    input  logic [15:0]   instr,
    input  logic          zFlag,        // Rs is zero
    input  logic          sFlag,        // Rs is negative
    output wiscPkg::ctrlT ctrl,
    output logic          takeBranch
);
    import wiscPkg::*;

    opcodeE op;

    assign op = opcodeE'(instr[15:11]);

    always_comb begin
        ctrl.regWrite  = 1'b0;
        ctrl.memEnable = 1'b0;
        ctrl.memWr     = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.pc2Reg    = 1'b0;
        ctrl.val2Reg   = 1'b0;
        ctrl.halt      = 1'b0;
        ctrl.isBranch  = 1'b0;
        ctrl.isJump    = 1'b0;
        ctrl.jumpReg   = 1'b0;
        ctrl.aluOp     = ALU_ADD;
        ctrl.immSel    = IMM_ZE5;
        ctrl.dstSel    = DST_RDI;
        takeBranch     = 1'b0;
        unique case (op)
            OP_HALT: ctrl.halt = 1'b1;
            OP_NOP, OP_SIIC, OP_RTI: ctrl.halt = 1'b0;  // No effect
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOpE'({instr[15], instr[12:11]});  // Low opcode bits map to ALU
                ctrl.immSel    = (instr[15] || instr[12]) ? IMM_ZE5 : IMM_SE5;  // ADDI SUBI signed
            end
            OP_ST, OP_LD, OP_STU: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = (op != OP_LD);
                ctrl.regWrite  = (op != OP_ST);
                ctrl.val2Reg   = (op == OP_LD);     // LD returns memory word
                ctrl.aluSrcImm = 1'b1;              // Address Rs+imm
                ctrl.immSel    = IMM_SE5;
                ctrl.dstSel    = (op == OP_STU) ? DST_RS : DST_RDI;  // STU updates base
            end
            OP_BTR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_BTR;
                ctrl.dstSel   = DST_RDR;
            end
            OP_RTYPE_ADD, OP_RTYPE_SHIFT: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOpE'({1'b0, instr[11] ? 1'b0 : 1'b1, instr[1:0]});
                ctrl.dstSel   = DST_RDR;
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOpE'({2'b10, instr[12:11]});
                ctrl.dstSel   = DST_RDR;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctrl.isBranch = 1'b1;
                ctrl.immSel   = IMM_SE8;
                unique case (instr[12:11])
                    2'b00: takeBranch = zFlag;      // BEQZ
                    2'b01: takeBranch = !zFlag;     // BNEZ
                    2'b10: takeBranch = sFlag;      // BLTZ
                    2'b11: takeBranch = !sFlag;     // BGEZ
                endcase
            end
            OP_LBI, OP_SLBI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = (op == OP_LBI) ? ALU_PASSB : ALU_SLBI;
                ctrl.immSel    = (op == OP_LBI) ? IMM_SE8 : IMM_ZE8;
                ctrl.dstSel    = DST_RS;
            end
            OP_J, OP_JAL, OP_JR, OP_JALR: begin
                ctrl.isJump    = 1'b1;
                ctrl.jumpReg   = instr[11];         // JR JALR
                ctrl.aluSrcImm = 1'b1;              // Rs+imm target in ALU
                ctrl.immSel    = instr[11] ? IMM_SE8 : IMM_SE11;
                ctrl.regWrite  = instr[12];         // Link forms
                ctrl.pc2Reg    = instr[12];
                ctrl.dstSel    = DST_R7;
            end
            default: ctrl.halt = 1'b0;              // Unknown word decodes as NOP
        endcase
    end

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
// WISC execute stage
`timescale 1ns/10ps
`default_nettype none
`include "wisc_cfg.svh"

module executeUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              bufValid,
    input  wiscPkg::fetchPktT bufPkt,
    output logic              redirect,
    output logic [15:0]       redirectPc,
    output logic              halted,
    output logic              retireValid,
    output wiscPkg::retireT   retire
);
    import wiscPkg::*;

    localparam int dmemAddrBits = $clog2(`WISC_DMEM_WORDS);

    ctrlT        ctrl;
    logic        takeBranch;
    logic [15:0] instr;
    logic [15:0] pcPlus2;
    logic [15:0] imm;
    logic [15:0] rsData;
    logic [15:0] rtData;        // Rt, or Rd for stores
    logic [15:0] aluB;
    logic [15:0] aluResult;
    logic [15:0] memRdData;
    logic [15:0] wrData;
    logic [2:0]  wrReg;
    logic        regWe;
    logic        memWe;
    logic [15:0] dmem [`WISC_DMEM_WORDS];

    assign instr   = bufPkt.instr;
    assign pcPlus2 = bufPkt.pc + 16'd2;

    control decode (.instr(instr), .zFlag(rsData == 16'h0000), .sFlag(rsData[15]),
                    .ctrl(ctrl), .takeBranch(takeBranch));

    always_comb begin
        case (ctrl.immSel)
            IMM_ZE5:  imm = {11'd0, instr[4:0]};
            IMM_SE5:  imm = {{11{instr[4]}}, instr[4:0]};
            IMM_ZE8:  imm = {8'd0, instr[7:0]};
            IMM_SE8:  imm = {{8{instr[7]}}, instr[7:0]};
            IMM_SE11: imm = {{5{instr[10]}}, instr[10:0]};
            default:  imm = 16'h0000;
        endcase
        unique case (ctrl.dstSel)
            DST_RDI: wrReg = instr[7:5];
            DST_RDR: wrReg = instr[4:2];
            DST_RS:  wrReg = instr[10:8];
            DST_R7:  wrReg = 3'd7;          // Link register
        endcase
    end

    assign regWe = bufValid && ctrl.regWrite;
    assign memWe = bufValid && ctrl.memEnable && ctrl.memWr;

    regFile regs (.clk(clk), .rst(rst), .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),
                  .wrEn(regWe), .wrAddr(wrReg), .wrData(wrData),
                  .rdDataA(rsData), .rdDataB(rtData));

    assign aluB = ctrl.aluSrcImm ? imm : rtData;

    alu aluInst (.op(ctrl.aluOp), .a(rsData), .b(aluB), .result(aluResult));

    assign memRdData = dmem[aluResult[dmemAddrBits:1]];     // LD reads combinationally

    always_ff @(posedge clk) begin
        if (memWe) begin
            dmem[aluResult[dmemAddrBits:1]] <= rtData;      // ST and STU
        end
    end

    // Link value, then memory, then ALU
    assign wrData = ctrl.pc2Reg ? pcPlus2 : (ctrl.val2Reg ? memRdData : aluResult);

    assign redirect   = bufValid && ((ctrl.isBranch && takeBranch) || ctrl.isJump);
    assign redirectPc = ctrl.jumpReg ? aluResult : pcPlus2 + imm;  // Rs+imm or relative

    always_ff @(posedge clk) begin
        if (rst) begin
            halted      <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            halted      <= halted || (bufValid && ctrl.halt);   // Sticky until reset
            retireValid <= bufValid;
        end
    end

    always_ff @(posedge clk) begin
        if (bufValid) begin
            retire.pc       <= bufPkt.pc;
            retire.regWrite <= ctrl.regWrite;
            retire.wrReg    <= ctrl.regWrite ? wrReg : 3'd0;
            retire.wrData   <= ctrl.regWrite ? wrData : 16'h0000;
            retire.memWrite <= ctrl.memWr;
            retire.memAddr  <= ctrl.memWr ? aluResult : 16'h0000;
            retire.memData  <= ctrl.memWr ? rtData : 16'h0000;
            retire.halted   <= ctrl.halt;
        end
    end

endmodule

`default_nettype wire

/* logic/fetchBuffer.sv */
// Fetch to execute buffer
`timescale 1ns/10ps
`default_nettype none

module fetchBuffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetchValid,
    input  wiscPkg::fetchPktT fetchPkt,
    input  logic              redirect,
    input  logic              halted,
    output logic              bufValid,
    output wiscPkg::fetchPktT bufPkt
);
    import wiscPkg::*;

    logic haltInBuf;

    // HALT now in execute, its successor must not follow it
    assign haltInBuf = bufValid && (bufPkt.instr[15:11] == OP_HALT);

    always_ff @(posedge clk) begin
        if (rst) begin
            bufValid <= 1'b0;
        end else begin
            bufValid <= fetchValid && !redirect && !halted && !haltInBuf;  // Wrong path dropped
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            bufPkt <= fetchPkt;     // Payload only
        end
    end

    // Once execute has halted the buffer never holds an entry
    emptyWhenHalted: assert property (@(posedge clk) disable iff (rst) halted |-> !bufValid)
        else $error("buffer valid while core halted");

endmodule

`default_nettype wire

/* logic/fetchUnit.sv */
// WISC fetch stage
`timescale 1ns/10ps
`default_nettype none
`include "wisc_cfg.svh"

module fetchUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,          // Fetch holds while low
    input  logic              imemWe,
    input  logic [15:0]       imemAddr,     // Byte address
    input  logic [15:0]       imemData,
    input  logic              redirect,
    input  logic [15:0]       redirectPc,
    input  logic              halted,
    output logic              fetchValid,
    output wiscPkg::fetchPktT fetchPkt
);
    localparam int imemAddrBits = $clog2(`WISC_IMEM_WORDS);

    logic [15:0] imem [`WISC_IMEM_WORDS];   // Instruction store
    logic [15:0] pc;

    // Issue unless stalled, stopped or about to be overridden
    assign fetchValid = run && !halted && !redirect;

    assign fetchPkt.instr = imem[pc[imemAddrBits:1]];  // Combinational read, word index
    assign fetchPkt.pc    = pc;

    // Load port from the outside world
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[imemAddrBits:1]] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `WISC_RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;       // Branch or jump target
        end else if (fetchValid) begin
            pc <= pc + 16'd2;       // Next sequential word
        end
    end

    // Targets computed in execute must keep word alignment
    pcEven: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
        else $error("fetch PC is odd: %h", pc);

endmodule

`default_nettype wire

/* logic/regFile.sv */
// WISC register file
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  rdAddrA,
    input  logic [2:0]  rdAddrB,
    input  logic        wrEn,
    input  logic [2:0]  wrAddr,
    input  logic [15:0] wrData,
    output logic [15:0] rdDataA,
    output logic [15:0] rdDataB
);
    logic [15:0] regs [8];  // R0 is writable

    assign rdDataA = regs[rdAddrA];     // Old value until the edge
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Destination comes from decode of the buffered word
    wrAddrKnown: assert property (@(posedge clk) disable iff (rst) wrEn |-> !$isunknown(wrAddr))
        else $error("register write with unknown address");

endmodule

`default_nettype wire

/* logic/wiscCore.sv */
// WISC two-stage core
`timescale 1ns/10ps
`default_nettype none

module wiscCore (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            imemWe,
    input  logic [15:0]     imemAddr,
    input  logic [15:0]     imemData,
    output logic            retireValid,
    output wiscPkg::retireT retire,
    output logic            halted
);
    import wiscPkg::*;

    logic        fetchValid;
    fetchPktT    fetchPkt;
    logic        bufValid;
    fetchPktT    bufPkt;
    logic        redirect;      // Taken branch or jump
    logic [15:0] redirectPc;

    fetchUnit fetch (.clk(clk), .rst(rst), .run(run), .imemWe(imemWe),
                     .imemAddr(imemAddr), .imemData(imemData),
                     .redirect(redirect), .redirectPc(redirectPc), .halted(halted),
                     .fetchValid(fetchValid), .fetchPkt(fetchPkt));

    fetchBuffer buffer (.clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchPkt(fetchPkt),
                        .redirect(redirect), .halted(halted),
                        .bufValid(bufValid), .bufPkt(bufPkt));

    executeUnit execute (.clk(clk), .rst(rst), .bufValid(bufValid), .bufPkt(bufPkt),
                         .redirect(redirect), .redirectPc(redirectPc), .halted(halted),
                         .retireValid(retireValid), .retire(retire));

endmodule

`default_nettype wire

/* logic/wiscPkg.sv */
// WISC core shared types
`default_nettype none

package wiscPkg;

    // Major opcode, instruction bits 15..11
    typedef enum logic [4:0] {
        OP_HALT        = 5'b00000,
        OP_NOP         = 5'b00001,
        OP_SIIC        = 5'b00010,  // Treated as NOP
        OP_RTI         = 5'b00011,  // Treated as NOP
        OP_J           = 5'b00100,
        OP_JR          = 5'b00101,
        OP_JAL         = 5'b00110,
        OP_JALR        = 5'b00111,
        OP_ADDI        = 5'b01000,
        OP_SUBI        = 5'b01001,
        OP_XORI        = 5'b01010,
        OP_ANDNI       = 5'b01011,
        OP_BEQZ        = 5'b01100,
        OP_BNEZ        = 5'b01101,
        OP_BLTZ        = 5'b01110,
        OP_BGEZ        = 5'b01111,
        OP_ST          = 5'b10000,
        OP_LD          = 5'b10001,
        OP_SLBI        = 5'b10010,
        OP_STU         = 5'b10011,
        OP_ROLI        = 5'b10100,
        OP_SLLI        = 5'b10101,
        OP_RORI        = 5'b10110,
        OP_SRLI        = 5'b10111,
        OP_LBI         = 5'b11000,
        OP_BTR         = 5'b11001,
        OP_RTYPE_SHIFT = 5'b11010,  // ROL SLL ROR SRL by func bits
        OP_RTYPE_ADD   = 5'b11011,  // ADD SUB XOR ANDN by func bits
        OP_SEQ         = 5'b11100,
        OP_SLT         = 5'b11101,
        OP_SLE         = 5'b11110,
        OP_SCO         = 5'b11111
    } opcodeE;

    // ALU operation, a is Rs and b is Rt or the immediate
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,   // b minus a
        ALU_XOR   = 4'd2,
        ALU_ANDN  = 4'd3,   // a and not b
        ALU_ROL   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_ROR   = 4'd6,
        ALU_SRL   = 4'd7,
        ALU_SEQ   = 4'd8,
        ALU_SLT   = 4'd9,
        ALU_SLE   = 4'd10,
        ALU_SCO   = 4'd11,
        ALU_BTR   = 4'd12,
        ALU_PASSB = 4'd13,
        ALU_SLBI  = 4'd14
    } aluOpE;

    typedef enum logic [2:0] {
        IMM_ZE5, IMM_SE5, IMM_ZE8, IMM_SE8, IMM_SE11
    } immSelE;

    typedef enum logic [1:0] {
        DST_RDI,    // Bits 7..5
        DST_RDR,    // Bits 4..2
        DST_RS,     // Bits 10..8
        DST_R7
    } dstSelE;

    typedef struct packed {
        logic   regWrite;
        logic   memEnable;
        logic   memWr;
        logic   aluSrcImm;  // ALU b from immediate
        logic   pc2Reg;     // Writeback pc+2
        logic   val2Reg;    // Writeback memory word
        logic   halt;
        logic   isBranch;
        logic   isJump;
        logic   jumpReg;    // Target from Rs+imm
        aluOpE  aluOp;
        immSelE immSel;
        dstSelE dstSel;
    } ctrlT;

    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] pc;
    } fetchPktT;

    // Unused fields read as zero
    typedef struct packed {
        logic [15:0] pc;
        logic        regWrite;
        logic [2:0]  wrReg;
        logic [15:0] wrData;
        logic        memWrite;
        logic [15:0] memAddr;
        logic [15:0] memData;
        logic        halted;
    } retireT;

endpackage

`default_nettype wire

/* logic/wisc_cfg.svh */
// WISC core configuration
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// Instruction memory depth in 16-bit words
`define WISC_IMEM_WORDS 256

// Data memory depth in 16-bit words
`define WISC_DMEM_WORDS 256

// First fetch address after reset
`define WISC_RESET_PC 16'h0000

`endif

/* tb/wiscCoreTb.sv */
// WISC core testbench
`timescale 1ns/10ps
`default_nettype none
`include "wisc_cfg.svh"

module wiscCoreTb;
    import wiscPkg::*;

    localparam int retireTimeout = 10;  // Cycles allowed per retire including a redirect bubble
    localparam int quietCycles   = 20;  // Silence required after HALT

    logic        clk;
    logic        rst;
    logic        run;
    logic        imemWe;
    logic [15:0] imemAddr;
    logic [15:0] imemData;
    logic        retireValid;
    logic        halted;
    retireT      retire;

    logic [15:0] progWord [$];  // Instruction word per row at pc 2*index
    retireT      expRec [$];    // Expected trace per row
    bit          skipRow [$];   // Row on a skipped path, never retires

    wiscCore dut (.clk(clk), .rst(rst), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
                  .imemData(imemData), .retireValid(retireValid), .retire(retire),
                  .halted(halted));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Instruction encoders
    function automatic logic [15:0] iFmt1(input opcodeE op, input logic [2:0] rs,
                                          input logic [2:0] rd, input logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] rFmt(input opcodeE op, input logic [2:0] rs,
                                         input logic [2:0] rt, input logic [2:0] rd,
                                         input logic [1:0] func);
        return {op, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] iFmt2(input opcodeE op, input logic [2:0] rs,
                                          input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] jFmt(input opcodeE op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    // Expected trace builders with pc left for addRow
    function automatic retireT noEffect();
        retireT r;
        r = '0;
        return r;
    endfunction

    function automatic retireT regResult(input logic [2:0] rd, input logic [15:0] data);
        retireT r;
        r          = '0;
        r.regWrite = 1'b1;
        r.wrReg    = rd;
        r.wrData   = data;
        return r;
    endfunction

    function automatic retireT memStore(input logic [15:0] addr, input logic [15:0] data);
        retireT r;
        r          = '0;
        r.memWrite = 1'b1;
        r.memAddr  = addr;
        r.memData  = data;
        return r;
    endfunction

    function automatic retireT storeUpdate(input logic [2:0] rs, input logic [15:0] addr,
                                           input logic [15:0] data);
        retireT r;
        r          = memStore(addr, data);
        r.regWrite = 1'b1;      // Base register gets the address
        r.wrReg    = rs;
        r.wrData   = addr;
        return r;
    endfunction

    function automatic retireT haltRecord();
        retireT r;
        r        = '0;
        r.halted = 1'b1;
        return r;
    endfunction

    task automatic addRow(input logic [15:0] word, input retireT rec, input bit skip);
        rec.pc = `WISC_RESET_PC + 16'(progWord.size() * 2);
        progWord.push_back(word);
        expRec.push_back(rec);
        skipRow.push_back(skip);
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        abortRun($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkRetire(input retireT got, input retireT exp);
        if (got.pc !== exp.pc) reportMismatch("retire.pc", got.pc, exp.pc);
        if (got.regWrite !== exp.regWrite)
            reportMismatch("retire.regWrite", 16'(got.regWrite), 16'(exp.regWrite));
        if (got.wrReg !== exp.wrReg)
            reportMismatch("retire.wrReg", 16'(got.wrReg), 16'(exp.wrReg));
        if (got.wrData !== exp.wrData)
            reportMismatch("retire.wrData", got.wrData, exp.wrData);
        if (got.memWrite !== exp.memWrite)
            reportMismatch("retire.memWrite", 16'(got.memWrite), 16'(exp.memWrite));
        if (got.memAddr !== exp.memAddr)
            reportMismatch("retire.memAddr", got.memAddr, exp.memAddr);
        if (got.memData !== exp.memData)
            reportMismatch("retire.memData", got.memData, exp.memData);
        if (got.halted !== exp.halted)
            reportMismatch("retire.halted", 16'(got.halted), 16'(exp.halted));
    endtask

    task automatic checkHalted(input logic exp);
        if (halted !== exp) reportMismatch("halted", 16'(halted), 16'(exp));
    endtask

    // Sampled at the falling edge where registered outputs are stable
    task automatic waitForRetire();
        int n;
        for (n = 0; n < retireTimeout; n++) begin
            @(negedge clk);
            if (retireValid === 1'b1) break;
        end
        if (n == retireTimeout)
            abortRun($sformatf("no instruction retired within %0d cycles", retireTimeout));
    endtask

    initial begin
        rst      = 1'b1;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = 16'h0000;
        imemData = 16'h0000;

        // Constants and I-format ALU immediates
        addRow(iFmt2(OP_LBI, 3'd1, 8'h12), regResult(3'd1, 16'h0012), 0);
        addRow(iFmt2(OP_SLBI, 3'd1, 8'h34), regResult(3'd1, 16'h1234), 0);
        addRow(iFmt2(OP_LBI, 3'd2, 8'hF0), regResult(3'd2, 16'hFFF0), 0);   // Sign extended
        addRow(iFmt1(OP_ADDI, 3'd1, 3'd3, 5'h1D), regResult(3'd3, 16'h1231), 0);  // Minus 3
        addRow(iFmt1(OP_SUBI, 3'd1, 3'd4, 5'd5), regResult(3'd4, 16'hEDD1), 0);   // 5 - R1
        addRow(iFmt1(OP_XORI, 3'd1, 3'd5, 5'h1F), regResult(3'd5, 16'h122B), 0);
        addRow(iFmt1(OP_ANDNI, 3'd1, 3'd6, 5'd7), regResult(3'd6, 16'h1230), 0);
        addRow(iFmt1(OP_ROLI, 3'd1, 3'd6, 5'd4), regResult(3'd6, 16'h2341), 0);
        addRow(iFmt1(OP_SLLI, 3'd1, 3'd6, 5'd8), regResult(3'd6, 16'h3400), 0);
        addRow(iFmt1(OP_RORI, 3'd1, 3'd6, 5'd4), regResult(3'd6, 16'h4123), 0);
        addRow(iFmt1(OP_SRLI, 3'd2, 3'd6, 5'd4), regResult(3'd6, 16'h0FFF), 0);
        // R-format group
        addRow(rFmt(OP_RTYPE_ADD, 3'd1, 3'd2, 3'd7, 2'b00), regResult(3'd7, 16'h1224), 0);
        addRow(rFmt(OP_RTYPE_ADD, 3'd1, 3'd3, 3'd7, 2'b01), regResult(3'd7, 16'hFFFD), 0);  // Rt - Rs
        addRow(rFmt(OP_RTYPE_ADD, 3'd1, 3'd2, 3'd7, 2'b10), regResult(3'd7, 16'hEDC4), 0);
        addRow(rFmt(OP_RTYPE_ADD, 3'd1, 3'd2, 3'd7, 2'b11), regResult(3'd7, 16'h0004), 0);
        addRow(rFmt(OP_RTYPE_SHIFT, 3'd1, 3'd6, 3'd7, 2'b00), regResult(3'd7, 16'h091A), 0);  // By 15
        addRow(rFmt(OP_RTYPE_SHIFT, 3'd1, 3'd3, 3'd7, 2'b01), regResult(3'd7, 16'h2468), 0);  // By 1
        addRow(rFmt(OP_RTYPE_SHIFT, 3'd1, 3'd5, 3'd7, 2'b10), regResult(3'd7, 16'h4682), 0);  // By 11
        addRow(rFmt(OP_RTYPE_SHIFT, 3'd2, 3'd3, 3'd7, 2'b11), regResult(3'd7, 16'h7FF8), 0);
        addRow(rFmt(OP_SEQ, 3'd1, 3'd1, 3'd7, 2'b00), regResult(3'd7, 16'h0001), 0);
        addRow(rFmt(OP_SLT, 3'd1, 3'd2, 3'd7, 2'b00), regResult(3'd7, 16'h0000), 0);  // R2 is -16
        addRow(rFmt(OP_SLE, 3'd3, 3'd1, 3'd7, 2'b00), regResult(3'd7, 16'h0001), 0);
        addRow(rFmt(OP_SCO, 3'd1, 3'd2, 3'd7, 2'b00), regResult(3'd7, 16'h0001), 0);
        addRow(rFmt(OP_BTR, 3'd1, 3'd0, 3'd7, 2'b00), regResult(3'd7, 16'h2C48), 0);
        // Memory
        addRow(iFmt2(OP_LBI, 3'd4, 8'h20), regResult(3'd4, 16'h0020), 0);
        addRow(iFmt1(OP_ST, 3'd4, 3'd1, 5'd4), memStore(16'h0024, 16'h1234), 0);
        addRow(iFmt1(OP_LD, 3'd4, 3'd5, 5'd4), regResult(3'd5, 16'h1234), 0);
        addRow(iFmt1(OP_STU, 3'd4, 3'd2, 5'h1E), storeUpdate(3'd4, 16'h001E, 16'hFFF0), 0);
        addRow(iFmt1(OP_LD, 3'd4, 3'd6, 5'd0), regResult(3'd6, 16'hFFF0), 0);
        // Branches where each taken one skips a row
        addRow(iFmt2(OP_BEQZ, 3'd0, 8'd2), noEffect(), 0);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_BEQZ, 3'd1, 8'd2), noEffect(), 0);   // Falls through
        addRow(iFmt2(OP_BNEZ, 3'd1, 8'd2), noEffect(), 0);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_BNEZ, 3'd0, 8'd2), noEffect(), 0);   // Falls through
        addRow(iFmt2(OP_BLTZ, 3'd2, 8'd2), noEffect(), 0);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_BLTZ, 3'd1, 8'd2), noEffect(), 0);   // Falls through
        addRow(iFmt2(OP_BGEZ, 3'd1, 8'd2), noEffect(), 0);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_BGEZ, 3'd2, 8'd2), noEffect(), 0);   // Falls through
        // Jumps
        addRow(jFmt(OP_JAL, 11'd4), regResult(3'd7, 16'h0054), 0);  // Link is pc+2
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(jFmt(OP_J, 11'd2), noEffect(), 0);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_LBI, 3'd3, 8'h60), regResult(3'd3, 16'h0060), 0);
        addRow(iFmt2(OP_JR, 3'd3, 8'd4), noEffect(), 0);            // To 0x0064
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_JALR, 3'd3, 8'd10), regResult(3'd7, 16'h0066), 0);  // To 0x006A
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt2(OP_LBI, 3'd3, 8'hEE), regResult(3'd3, 16'hFFEE), 1);
        addRow(iFmt1(OP_ADDI, 3'd7, 3'd1, 5'd0), regResult(3'd1, 16'h0066), 0);  // Reads link
        addRow(jFmt(OP_NOP, 11'd0), noEffect(), 0);
        addRow(jFmt(OP_HALT, 11'd0), haltRecord(), 0);

        // Program load with reset released after the second edge
        for (int i = 0; i < progWord.size(); i++) begin
            @(posedge clk);
            #1;
            if (i == 1) rst = 1'b0;
            imemWe   = 1'b1;
            imemAddr = `WISC_RESET_PC + 16'(i * 2);
            imemData = progWord[i];
        end
        @(posedge clk);
        #1;
        imemWe = 1'b0;
        if (retireValid !== 1'b0) abortRun("retire strobe seen before run was raised");
        checkHalted(1'b0);
        run = 1'b1;

        for (int i = 0; i < progWord.size(); i++) begin
            if (!skipRow[i]) begin
                waitForRetire();
                checkRetire(retire, expRec[i]);
            end
        end
        checkHalted(1'b1);  // Rises with the HALT trace

        for (int n = 0; n < quietCycles; n++) begin
            @(negedge clk);
            if (retireValid !== 1'b0) abortRun("an instruction retired after HALT");
            checkHalted(1'b1);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* wiscCore.f */
+incdir+logic
logic/wiscPkg.sv
logic/fetchUnit.sv
logic/fetchBuffer.sv
logic/control.sv
logic/regFile.sv
logic/alu.sv
logic/executeUnit.sv
logic/wiscCore.sv
tb/wiscCoreTb.sv
